//--- verilog/bridge_cmd_pkg.sv
package bridge_cmd_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [7:0] status_t;

  typedef enum logic [1:0] {
    CMD_WRITE,
    CMD_READ,
    CMD_BAD
  } cmd_op_e;

  // Opcodes on the host stream
  localparam byte_t OPC_WRITE = 8'h01;
  localparam byte_t OPC_READ = 8'h02;

  // Opcode byte plus address and data bytes
  localparam int WRITE_FRAME_LEN = 9;
  localparam int READ_FRAME_LEN = 5;

  localparam status_t STAT_OKAY = 8'h00;
  localparam status_t STAT_DECERR = 8'h03;
  localparam status_t STAT_BADCMD = 8'hEE;

  localparam int READ_REPLY_LEN = 5;

endpackage

//--- verilog/bridge_mem_pkg.sv
package bridge_mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_DECERR = 2'b11;

  // Depth in 32-bit words
  localparam int MEM_WORDS = 1024;

  // Read acceptance to rvalid
  localparam int MEM_RD_LATENCY = 2;

endpackage

//--- verilog/cmd_decode.sv
`timescale 1ns/1ps
module cmd_decode
  import bridge_cmd_pkg::*;
  import bridge_mem_pkg::*;
(
  input  logic    clock,
  input  logic    rst_n_i,
  input  logic    s_valid_i,
  input  logic    s_last_i,
  input  byte_t   s_data_i,
  output logic    s_ready_o,
  input  logic    cmd_busy_i,
  output logic    cmd_valid_o,
  output cmd_op_e cmd_op_o,
  output addr_t   cmd_addr_o,
  output data_t   cmd_wdata_o
);

  typedef enum logic [2:0] {IDLE, ADDR, DATA, DRAIN, HOLD} state_e;

  state_e state_q, eff_state, nxt_state;
  logic [3:0] cnt_q, cnt_n, flen_q, flen_n;
  cmd_op_e op_q, op_n;
  addr_t addr_q, addr_n;
  data_t wdata_q, wdata_n;
  logic last_seen_q, rdy_q, busy, issue_held, take, done;

  // A strobe in flight counts as busy, the executor sees it a cycle later
  assign busy = cmd_busy_i | cmd_valid_o;
  assign issue_held = (state_q == HOLD) && !busy;
  assign s_ready_o = rdy_q && !((state_q == HOLD) && busy);
  assign take = s_valid_i && s_ready_o;

  always_comb begin
    eff_state = state_q;
    if (state_q == HOLD) begin
      eff_state = last_seen_q ? IDLE : DRAIN;
    end
    nxt_state = issue_held ? eff_state : state_q;
    op_n = op_q;
    addr_n = addr_q;
    wdata_n = wdata_q;
    flen_n = flen_q;
    cnt_n = cnt_q;
    done = 1'b0;
    if (take) begin
      case (eff_state)
        IDLE: begin
          cnt_n = 4'd1;
          if (s_data_i == OPC_WRITE) begin
            op_n = CMD_WRITE;
            flen_n = 4'(WRITE_FRAME_LEN);
          end else if (s_data_i == OPC_READ) begin
            op_n = CMD_READ;
            flen_n = 4'(READ_FRAME_LEN);
          end else begin
            op_n = CMD_BAD;
          end
          if (s_last_i) begin
            op_n = CMD_BAD;
            done = 1'b1;
          end else begin
            nxt_state = (op_n == CMD_BAD) ? DRAIN : ADDR;
          end
        end
        ADDR, DATA: begin
          cnt_n = cnt_q + 4'd1;
          // LSB first, so each byte enters at the top
          if (eff_state == ADDR) begin
            addr_n = {s_data_i, addr_q[31:8]};
          end else begin
            wdata_n = {s_data_i, wdata_q[31:8]};
          end
          if (cnt_n == flen_q) begin
            done = 1'b1;
          end else if (s_last_i) begin
            op_n = CMD_BAD;
            done = 1'b1;
          end else if (cnt_n == 4'(READ_FRAME_LEN)) begin
            nxt_state = DATA;
          end
        end
        DRAIN: begin
          if (s_last_i) begin
            nxt_state = IDLE;
            done = (op_q == CMD_BAD);
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      rdy_q <= 1'b0;
      cmd_valid_o <= 1'b0;
      last_seen_q <= 1'b0;
      cnt_q <= 4'd0;
      flen_q <= 4'd0;
    end else begin
      rdy_q <= 1'b1;
      cnt_q <= cnt_n;
      flen_q <= flen_n;
      state_q <= nxt_state;
      cmd_valid_o <= issue_held;
      if (done) begin
        last_seen_q <= s_last_i;
        if (busy || issue_held) begin
          state_q <= HOLD;
        end else begin
          cmd_valid_o <= 1'b1;
          state_q <= s_last_i ? IDLE : DRAIN;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    op_q <= op_n;
    addr_q <= addr_n;
    wdata_q <= wdata_n;
    if (issue_held) begin
      cmd_op_o <= op_q;
      cmd_addr_o <= addr_q;
      cmd_wdata_o <= wdata_q;
    end else if (done && !busy) begin
      cmd_op_o <= op_n;
      cmd_addr_o <= addr_n;
      cmd_wdata_o <= wdata_n;
    end
  end

endmodule

//--- verilog/axi_execute.sv
`timescale 1ns/1ps
module axi_execute
  import bridge_cmd_pkg::*;
  import bridge_mem_pkg::*;
(
  input  logic    clock,
  input  logic    rst_n_i,
  input  logic    cmd_valid_i,
  input  cmd_op_e cmd_op_i,
  input  addr_t   cmd_addr_i,
  input  data_t   cmd_wdata_i,
  output logic    cmd_busy_o,
  output logic    awvalid_o,
  input  logic    awready_i,
  output addr_t   awaddr_o,
  output logic    wvalid_o,
  input  logic    wready_i,
  output data_t   wdata_o,
  input  logic    bvalid_i,
  output logic    bready_o,
  input  resp_t   bresp_i,
  output logic    arvalid_o,
  input  logic    arready_i,
  output addr_t   araddr_o,
  input  logic    rvalid_i,
  output logic    rready_o,
  input  resp_t   rresp_i,
  input  data_t   rdata_i,
  output logic    res_valid_o,
  output cmd_op_e res_op_o,
  output status_t res_status_o,
  output data_t   res_rdata_o,
  input  logic    reply_done_i
);

  typedef enum logic [2:0] {EX_IDLE, EX_WRITE, EX_BRESP, EX_READ, EX_RRESP, EX_WAIT} state_e;

  state_e state_q;

  function automatic status_t map_resp(input resp_t resp);
    return (resp == RESP_OKAY) ? STAT_OKAY : STAT_DECERR;
  endfunction

  // Busy covers execution and the whole reply
  assign cmd_busy_o = (state_q != EX_IDLE);

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q <= EX_IDLE;
      awvalid_o <= 1'b0;
      wvalid_o <= 1'b0;
      bready_o <= 1'b0;
      arvalid_o <= 1'b0;
      rready_o <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= 1'b0;
      case (state_q)
        EX_IDLE: begin
          if (cmd_valid_i) begin
            case (cmd_op_i)
              CMD_WRITE: begin
                awvalid_o <= 1'b1;
                wvalid_o <= 1'b1;
                state_q <= EX_WRITE;
              end
              CMD_READ: begin
                arvalid_o <= 1'b1;
                state_q <= EX_READ;
              end
              default: begin
                res_valid_o <= 1'b1;
                state_q <= EX_WAIT;
              end
            endcase
          end
        end
        EX_WRITE: begin
          if (awready_i) begin
            awvalid_o <= 1'b0;
          end
          if (wready_i) begin
            wvalid_o <= 1'b0;
          end
          // Both channels done, counting this cycle's handshakes
          if ((!awvalid_o || awready_i) && (!wvalid_o || wready_i)) begin
            bready_o <= 1'b1;
            state_q <= EX_BRESP;
          end
        end
        EX_BRESP: begin
          if (bvalid_i) begin
            bready_o <= 1'b0;
            res_valid_o <= 1'b1;
            state_q <= EX_WAIT;
          end
        end
        EX_READ: begin
          if (arready_i) begin
            arvalid_o <= 1'b0;
            rready_o <= 1'b1;
            state_q <= EX_RRESP;
          end
        end
        EX_RRESP: begin
          if (rvalid_i) begin
            rready_o <= 1'b0;
            res_valid_o <= 1'b1;
            state_q <= EX_WAIT;
          end
        end
        EX_WAIT: begin
          if (reply_done_i) begin
            state_q <= EX_IDLE;
          end
        end
        default: state_q <= EX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_valid_i && (state_q == EX_IDLE)) begin
      awaddr_o <= cmd_addr_i;
      araddr_o <= cmd_addr_i;
      wdata_o <= cmd_wdata_i;
      res_op_o <= cmd_op_i;
      res_status_o <= STAT_BADCMD;
      res_rdata_o <= '0;
    end else if ((state_q == EX_BRESP) && bvalid_i) begin
      res_status_o <= map_resp(bresp_i);
    end else if ((state_q == EX_RRESP) && rvalid_i) begin
      res_status_o <= map_resp(rresp_i);
      res_rdata_o <= (rresp_i == RESP_OKAY) ? rdata_i : '0;
    end
  end

endmodule

//--- verilog/reply_encode.sv
`timescale 1ns/1ps
module reply_encode
  import bridge_cmd_pkg::*;
  import bridge_mem_pkg::*;
(
  input  logic    clock,
  input  logic    rst_n_i,
  input  logic    res_valid_i,
  input  cmd_op_e res_op_i,
  input  status_t res_status_i,
  input  data_t   res_rdata_i,
  output logic    m_valid_o,
  input  logic    m_ready_i,
  output logic    m_last_o,
  output byte_t   m_data_o,
  output logic    reply_done_o
);

  // Status byte in the low byte, read data above it
  logic [39:0] sh_q;
  logic [2:0] left_q;
  logic xfer;

  assign xfer = m_valid_o && m_ready_i;
  assign m_data_o = sh_q[7:0];
  assign m_last_o = m_valid_o && (left_q == 3'd1);
  assign reply_done_o = xfer && m_last_o;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      m_valid_o <= 1'b0;
      left_q <= 3'd0;
    end else if (res_valid_i) begin
      m_valid_o <= 1'b1;
      if (res_op_i == CMD_READ) begin
        left_q <= 3'(READ_REPLY_LEN);
      end else begin
        left_q <= 3'd1;
      end
    end else if (xfer) begin
      left_q <= left_q - 3'd1;
      if (left_q == 3'd1) begin
        m_valid_o <= 1'b0;
      end
    end
  end

  // Next byte only moves down once the current one is taken
  always_ff @(posedge clock) begin
    if (res_valid_i) begin
      sh_q <= {res_rdata_i, res_status_i};
    end else if (xfer) begin
      sh_q <= {8'h00, sh_q[39:8]};
    end
  end

endmodule

//--- verilog/axi_mem_lite.sv
`timescale 1ns/1ps
module axi_mem_lite
  import bridge_mem_pkg::*;
(
  input  logic  clock,
  input  logic  rst_n_i,
  input  logic  awvalid_i,
  output logic  awready_o,
  input  addr_t awaddr_i,
  input  logic  wvalid_i,
  output logic  wready_o,
  input  data_t wdata_i,
  output logic  bvalid_o,
  input  logic  bready_i,
  output resp_t bresp_o,
  input  logic  arvalid_i,
  output logic  arready_o,
  input  addr_t araddr_i,
  output logic  rvalid_o,
  input  logic  rready_i,
  output resp_t rresp_o,
  output data_t rdata_o
);

  data_t mem [MEM_WORDS];
  logic [MEM_RD_LATENCY-2:0] rd_pipe_q;
  logic wr_acc, rd_acc, wr_in_range, rd_in_range, rd_busy;

  assign wr_in_range = (awaddr_i < addr_t'(MEM_WORDS * 4));
  assign rd_in_range = (araddr_i < addr_t'(MEM_WORDS * 4));

  // Address and data taken together, one write response outstanding
  assign wr_acc = awvalid_i && wvalid_i && !bvalid_o;
  assign awready_o = wr_acc;
  assign wready_o = wr_acc;

  assign rd_busy = (|rd_pipe_q) || rvalid_o;
  assign rd_acc = arvalid_i && !rd_busy;
  assign arready_o = rd_acc;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      bvalid_o <= 1'b0;
      rvalid_o <= 1'b0;
      rd_pipe_q <= '0;
    end else begin
      if (wr_acc) begin
        bvalid_o <= 1'b1;
      end else if (bready_i) begin
        bvalid_o <= 1'b0;
      end
      rd_pipe_q <= (rd_pipe_q << 1) | rd_acc;
      if (rd_pipe_q[MEM_RD_LATENCY-2]) begin
        rvalid_o <= 1'b1;
      end else if (rready_i) begin
        rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (wr_acc) begin
      bresp_o <= wr_in_range ? RESP_OKAY : RESP_DECERR;
      if (wr_in_range) begin
        mem[awaddr_i[$clog2(MEM_WORDS)+1:2]] <= wdata_i;
      end
    end
    if (rd_acc) begin
      rresp_o <= rd_in_range ? RESP_OKAY : RESP_DECERR;
      rdata_o <= rd_in_range ? mem[araddr_i[$clog2(MEM_WORDS)+1:2]] : '0;
    end
  end

endmodule

//--- verilog/axis_mem_bridge_top.sv
`timescale 1ns/1ps
module axis_mem_bridge_top
  import bridge_cmd_pkg::*;
  import bridge_mem_pkg::*;
(
  input  logic  clock,
  input  logic  rst_n_i,
  input  logic  s_valid_i,
  output logic  s_ready_o,
  input  logic  s_last_i,
  input  byte_t s_data_i,
  output logic  m_valid_o,
  input  logic  m_ready_i,
  output logic  m_last_o,
  output byte_t m_data_o
);

  logic cmd_valid, cmd_busy;
  cmd_op_e cmd_op;
  addr_t cmd_addr;
  data_t cmd_wdata;

  // Memory bus between executor and core
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  addr_t awaddr, araddr;
  data_t wdata, rdata;
  resp_t bresp, rresp;

  logic res_valid, reply_done;
  cmd_op_e res_op;
  status_t res_status;
  data_t res_rdata;

  cmd_decode decode_i (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .s_valid_i  (s_valid_i),
    .s_last_i   (s_last_i),
    .s_data_i   (s_data_i),
    .s_ready_o  (s_ready_o),
    .cmd_busy_i (cmd_busy),
    .cmd_valid_o(cmd_valid),
    .cmd_op_o   (cmd_op),
    .cmd_addr_o (cmd_addr),
    .cmd_wdata_o(cmd_wdata)
  );

  axi_execute execute_i (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_op_i    (cmd_op),
    .cmd_addr_i  (cmd_addr),
    .cmd_wdata_i (cmd_wdata),
    .cmd_busy_o  (cmd_busy),
    .awvalid_o   (awvalid),
    .awready_i   (awready),
    .awaddr_o    (awaddr),
    .wvalid_o    (wvalid),
    .wready_i    (wready),
    .wdata_o     (wdata),
    .bvalid_i    (bvalid),
    .bready_o    (bready),
    .bresp_i     (bresp),
    .arvalid_o   (arvalid),
    .arready_i   (arready),
    .araddr_o    (araddr),
    .rvalid_i    (rvalid),
    .rready_o    (rready),
    .rresp_i     (rresp),
    .rdata_i     (rdata),
    .res_valid_o (res_valid),
    .res_op_o    (res_op),
    .res_status_o(res_status),
    .res_rdata_o (res_rdata),
    .reply_done_i(reply_done)
  );

  reply_encode reply_i (
    .clock       (clock),
    .rst_n_i     (rst_n_i),
    .res_valid_i (res_valid),
    .res_op_i    (res_op),
    .res_status_i(res_status),
    .res_rdata_i (res_rdata),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .m_last_o    (m_last_o),
    .m_data_o    (m_data_o),
    .reply_done_o(reply_done)
  );

  axi_mem_lite mem_i (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .awvalid_i(awvalid),
    .awready_o(awready),
    .awaddr_i (awaddr),
    .wvalid_i (wvalid),
    .wready_o (wready),
    .wdata_i  (wdata),
    .bvalid_o (bvalid),
    .bready_i (bready),
    .bresp_o  (bresp),
    .arvalid_i(arvalid),
    .arready_o(arready),
    .araddr_i (araddr),
    .rvalid_o (rvalid),
    .rready_i (rready),
    .rresp_o  (rresp),
    .rdata_o  (rdata)
  );

endmodule

//--- testbench/tb_bridge_sva.sv
`timescale 1ns/1ps
module tb_bridge_sva
  import bridge_mem_pkg::*;
(
  input logic       clock_i,
  input logic       rst_n_i,
  input logic       s_valid_i,
  input logic       s_ready_i,
  input logic       s_last_i,
  input logic [7:0] s_data_i,
  input logic       m_valid_i,
  input logic       m_ready_i,
  input logic       m_last_i,
  input logic [7:0] m_data_i,
  input logic       cmd_valid_i,
  input logic       cmd_busy_i,
  input logic       awvalid_i,
  input logic       awready_i,
  input logic       wvalid_i,
  input logic       wready_i,
  input logic       bvalid_i,
  input logic       bready_i,
  input logic       arvalid_i,
  input logic       arready_i,
  input logic       rvalid_i,
  input logic       rready_i
);

  int fail_count = 0;

  s_stall_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    s_valid_i && !s_ready_i |=> s_valid_i && $stable(s_data_i) && $stable(s_last_i))
    else begin
      $error("input stream byte changed while stalled");
      fail_count++;
    end

  m_stall_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_data_i) && $stable(m_last_i))
    else begin
      $error("reply stream byte changed while stalled");
      fail_count++;
    end

  m_last_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    m_last_i |-> m_valid_i)
    else begin
      $error("m_last_o without m_valid_o");
      fail_count++;
    end

  cmd_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    cmd_valid_i |-> !cmd_busy_i)
    else begin
      $error("cmd_valid while executor busy");
      fail_count++;
    end

  aw_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    awvalid_i && !awready_i |=> awvalid_i)
    else begin
      $error("awvalid dropped before awready");
      fail_count++;
    end

  w_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    wvalid_i && !wready_i |=> wvalid_i)
    else begin
      $error("wvalid dropped before wready");
      fail_count++;
    end

  ar_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    arvalid_i && !arready_i |=> arvalid_i)
    else begin
      $error("arvalid dropped before arready");
      fail_count++;
    end

  b_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end

  r_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end

  // Read data appears a fixed number of cycles after the address is taken
  rd_lat_a: assert property (@(posedge clock_i) disable iff (!rst_n_i)
    $rose(rvalid_i) |-> $past(arvalid_i && arready_i, MEM_RD_LATENCY))
    else begin
      $error("rvalid not at the memory read latency after arready");
      fail_count++;
    end

endmodule

bind axis_mem_bridge_top tb_bridge_sva sva_i (
  .clock_i    (clock),
  .rst_n_i    (rst_n_i),
  .s_valid_i  (s_valid_i),
  .s_ready_i  (s_ready_o),
  .s_last_i   (s_last_i),
  .s_data_i   (s_data_i),
  .m_valid_i  (m_valid_o),
  .m_ready_i  (m_ready_i),
  .m_last_i   (m_last_o),
  .m_data_i   (m_data_o),
  .cmd_valid_i(cmd_valid),
  .cmd_busy_i (cmd_busy),
  .awvalid_i  (awvalid),
  .awready_i  (awready),
  .wvalid_i   (wvalid),
  .wready_i   (wready),
  .bvalid_i   (bvalid),
  .bready_i   (bready),
  .arvalid_i  (arvalid),
  .arready_i  (arready),
  .rvalid_i   (rvalid),
  .rready_i   (rready)
);

//--- testbench/tb_reply_checker.sv
`timescale 1ns/1ps
module tb_reply_checker
  import bridge_cmd_pkg::*;
(
  input  logic  clock_i,
  input  logic  rst_n_i,
  input  logic  exp_valid_i,
  input  logic  exp_last_i,
  input  byte_t exp_data_i,
  input  logic  s_ready_i,
  input  logic  m_valid_i,
  input  logic  m_ready_i,
  input  logic  m_last_i,
  input  byte_t m_data_i,
  output int    seen_o,
  output int    data_errs_o,
  output int    last_errs_o,
  output int    other_errs_o
);

  // Last flag in bit 8
  logic [8:0] exp_q [$];
  logic [8:0] exp_word;
  int seen = 0;
  int data_errs = 0;
  int last_errs = 0;
  int other_errs = 0;

  assign seen_o = seen;
  assign data_errs_o = data_errs;
  assign last_errs_o = last_errs;
  assign other_errs_o = other_errs;

  // Everything here is stable by the falling edge
  always @(negedge clock_i) begin
    if (exp_valid_i) begin
      exp_q.push_back({exp_last_i, exp_data_i});
    end
    if (!rst_n_i) begin
      if (m_valid_i !== 1'b0) begin
        $display("[FAIL] t=%0t m_valid_o expected 0 actual %b", $time, m_valid_i);
        other_errs++;
      end
      if (m_last_i !== 1'b0) begin
        $display("[FAIL] t=%0t m_last_o expected 0 actual %b", $time, m_last_i);
        other_errs++;
      end
      if (s_ready_i !== 1'b0) begin
        $display("[FAIL] t=%0t s_ready_o expected 0 actual %b", $time, s_ready_i);
        other_errs++;
      end
    end else if (m_valid_i && m_ready_i) begin
      seen++;
      if (exp_q.size() == 0) begin
        $display("At %0t reply byte 0x%02h arrived with no reply outstanding",
                 $time, m_data_i);
        other_errs++;
      end else begin
        exp_word = exp_q.pop_front();
        if (m_data_i !== exp_word[7:0]) begin
          $display("[FAIL] t=%0t m_data_o expected 0x%02h actual 0x%02h",
                   $time, exp_word[7:0], m_data_i);
          data_errs++;
        end
        if (m_last_i !== exp_word[8]) begin
          $display("[FAIL] t=%0t m_last_o expected %0b actual %0b",
                   $time, exp_word[8], m_last_i);
          last_errs++;
        end
      end
    end
  end

endmodule

//--- testbench/tb_axis_mem_bridge.sv
`timescale 1ns/1ps
module tb_axis_mem_bridge
  import bridge_cmd_pkg::*;
();

  localparam int CLK_HALF = 50;
  localparam int RESET_CYCLES = 16;
  localparam int STIM_DEPTH = 512;
  localparam int CYCLES_PER_FRAME = 200;

  logic clock = 1'b0;
  logic rst_n_i;
  logic s_valid_i;
  logic s_ready_o;
  logic s_last_i;
  byte_t s_data_i;
  logic m_valid_o;
  logic m_ready_i = 1'b0;
  logic m_last_o;
  byte_t m_data_o;

  // Expected reply bytes into the checker
  logic exp_valid;
  logic exp_last;
  byte_t exp_data;

  byte_t stim [STIM_DEPTH];
  int seed = 90877;
  logic [1:0] gap_rnd = 2'd0;
  int frames_total = 0;
  int bytes_expected = 0;
  int seen_bytes;
  int data_errs;
  int last_errs;
  int other_errs;

  axis_mem_bridge_top dut_i (
    .clock    (clock),
    .rst_n_i  (rst_n_i),
    .s_valid_i(s_valid_i),
    .s_ready_o(s_ready_o),
    .s_last_i (s_last_i),
    .s_data_i (s_data_i),
    .m_valid_o(m_valid_o),
    .m_ready_i(m_ready_i),
    .m_last_o (m_last_o),
    .m_data_o (m_data_o)
  );

  tb_reply_checker checker_i (
    .clock_i     (clock),
    .rst_n_i     (rst_n_i),
    .exp_valid_i (exp_valid),
    .exp_last_i  (exp_last),
    .exp_data_i  (exp_data),
    .s_ready_i   (s_ready_o),
    .m_valid_i   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .m_last_i    (m_last_o),
    .m_data_i    (m_data_o),
    .seen_o      (seen_bytes),
    .data_errs_o (data_errs),
    .last_errs_o (last_errs),
    .other_errs_o(other_errs)
  );

  always #CLK_HALF clock = ~clock;

  // Back-pressure and byte gaps share one random stream
  always @(posedge clock) begin
    int rnd;
    #1;
    rnd = $random(seed);
    m_ready_i <= (rnd[1:0] != 2'b00);
    gap_rnd <= rnd[5:4];
  end

  function automatic int count_frames();
    int idx;
    int n;
    idx = 0;
    n = 0;
    while (idx < STIM_DEPTH && stim[idx] != 8'h00) begin
      idx += int'(stim[idx]) + int'(stim[idx + int'(stim[idx]) + 1]) + 2;
      n++;
    end
    return n;
  endfunction

  task automatic send_byte(input byte_t data, input logic last);
    logic taken;
    taken = 1'b0;
    s_valid_i = 1'b1;
    s_data_i = data;
    s_last_i = last;
    // Ready depends on DUT state only, so it is settled at the falling edge
    while (!taken) begin
      @(negedge clock);
      taken = s_ready_o;
      @(posedge clock);
    end
    #1;
    s_valid_i = 1'b0;
    s_last_i = 1'b0;
  endtask

  task automatic push_reply(input int base, input int count);
    for (int k = 0; k < count; k++) begin
      exp_valid = 1'b1;
      exp_data = stim[base + k];
      exp_last = (k == count - 1);
      @(posedge clock);
      #1;
    end
    exp_valid = 1'b0;
  endtask

  task automatic send_frame(input int base, input int count);
    for (int k = 0; k < count; k++) begin
      send_byte(stim[base + k], k == count - 1);
      repeat (gap_rnd) begin
        @(posedge clock);
        #1;
      end
    end
  endtask

  initial begin
    int idx;
    int n;
    int r;
    rst_n_i = 1'b0;
    s_valid_i = 1'b0;
    s_last_i = 1'b0;
    s_data_i = 8'h00;
    exp_valid = 1'b0;
    exp_last = 1'b0;
    exp_data = 8'h00;
    $readmemh("testbench/tb_input.txt", stim);
    frames_total = count_frames();
    if (frames_total == 0) begin
      $display("No command frames found in testbench/tb_input.txt");
      $display("Regression failed");
    end else begin
      repeat (RESET_CYCLES) @(posedge clock);
      #1;
      rst_n_i = 1'b1;
      idx = 0;
      // Frames go out without waiting for replies
      while (idx < STIM_DEPTH && stim[idx] != 8'h00) begin
        n = int'(stim[idx]);
        r = int'(stim[idx + n + 1]);
        push_reply(idx + n + 2, r);
        bytes_expected += r;
        send_frame(idx + 1, n);
        idx += n + r + 2;
      end
      wait (seen_bytes >= bytes_expected);
      repeat (20) @(posedge clock);
      $display("Errors: data %0d, last %0d, other %0d, assertions %0d; reply bytes %0d of %0d",
               data_errs, last_errs, other_errs, dut_i.sva_i.fail_count,
               seen_bytes, bytes_expected);
      if (data_errs + last_errs + other_errs + dut_i.sva_i.fail_count == 0 &&
          seen_bytes == bytes_expected) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (frames_total > 0);
    repeat (frames_total * CYCLES_PER_FRAME + RESET_CYCLES) @(posedge clock);
    $display("Timeout with %0d of %0d reply bytes received", seen_bytes, bytes_expected);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- testbench/tb_input.txt
// Each record is a frame byte count and the frame bytes
// then a reply byte count and the expected reply bytes
// A count of 00 ends the list
// In-range write then read back
09 01 10 00 00 00 EF BE AD DE 01 00
05 02 10 00 00 00 05 00 EF BE AD DE
// Out of range read and write, then confirm memory unchanged
05 02 00 10 00 00 05 03 00 00 00 00
09 01 10 10 00 00 44 33 22 11 01 03
05 02 10 00 00 00 05 00 EF BE AD DE
// Unknown opcode, short write, opcode only
03 7F 01 02 01 EE
05 01 20 00 00 00 01 EE
01 02 01 EE
// Extra bytes after complete frames
0B 01 24 00 00 00 78 56 34 12 AA BB 01 00
07 02 24 00 00 00 55 66 05 00 78 56 34 12
// Top word of memory and a high address
09 01 FC 0F 00 00 0D F0 FE CA 01 00
05 02 FC 0F 00 00 05 00 0D F0 FE CA
05 02 00 00 00 80 05 03 00 00 00 00
09 01 00 01 00 00 5A 5A A5 A5 01 00
05 02 00 01 00 00 05 00 5A 5A A5 A5
02 FF 00 01 EE
05 02 10 00 00 00 05 00 EF BE AD DE
00

//--- axis_mem_bridge.f
verilog/bridge_cmd_pkg.sv
verilog/bridge_mem_pkg.sv
verilog/cmd_decode.sv
verilog/axi_execute.sv
verilog/reply_encode.sv
verilog/axi_mem_lite.sv
verilog/axis_mem_bridge_top.sv
testbench/tb_bridge_sva.sv
testbench/tb_reply_checker.sv
testbench/tb_axis_mem_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_axis_mem_bridge -f axis_mem_bridge.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_axis_mem_bridge)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
